/* Makefile */
VERILATOR ?= verilator
TOP       ?= cache_tb
FILE_LIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SOURCES := $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILE_LIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

# the log decides, the simulator exit code is hidden by tee
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Testbench passed" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/cache_bus_pkg.sv */
package cache_bus_pkg;

  // cpu side, sampled as a level while idle
  typedef struct packed {
    cache_geom_pkg::cache_addr_u address;
    cache_geom_pkg::cache_word_t data;
    logic                        write_enable;
    logic                        read_enable;
  } cpu_req_s;

  typedef struct packed {
    logic                        data_ready;
    cache_geom_pkg::cache_word_t data;
  } cpu_rsp_s;

  // memory bus, write enable is a single pulse
  typedef struct packed {
    cache_geom_pkg::cache_addr_u fetch_address;
    cache_geom_pkg::cache_word_t fetch_write_data;
    logic                        fetch_write_enable;
  } mem_req_s;

  // broadcast to every line, each line checks the index
  typedef struct packed {
    logic                        enable;
    cache_geom_pkg::cache_index_t index;
    cache_geom_pkg::cache_tag_t  tag;
    cache_geom_pkg::cache_word_t data;
  } line_write_s;

  // one line's lookup answer
  typedef struct packed {
    logic                        hit;
    cache_geom_pkg::cache_word_t data;
  } line_read_s;

  // combined answer over all lines
  typedef struct packed {
    logic                        hit;
    cache_geom_pkg::cache_word_t data;
  } lookup_s;

  typedef enum logic [1:0] {
    IDLE  = 2'b00,
    READ  = 2'b01,
    WRITE = 2'b10
  } ctrl_state_e;

endpackage

/* hw/cache_ctrl.sv */
module cache_ctrl (
  input  logic                        clk,
  input  logic                        reset,
  input  cache_bus_pkg::cpu_req_s     cpu_req,
  output cache_bus_pkg::cpu_rsp_s     cpu_rsp,
  output cache_bus_pkg::mem_req_s     mem_req,
  input  cache_geom_pkg::cache_word_t fetch_read_data,
  output cache_geom_pkg::cache_addr_u lookup_addr,
  output cache_bus_pkg::line_write_s  line_write,
  input  cache_bus_pkg::lookup_s      lookup
);

  cache_bus_pkg::ctrl_state_e  state;
  cache_bus_pkg::cpu_req_s     req;
  cache_geom_pkg::cache_addr_u word_addr;
  logic                        fetch_match;
  logic                        start;

  assign start = (state == cache_bus_pkg::IDLE) &&
                 (cpu_req.write_enable || cpu_req.read_enable);

  // request held for the whole access
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      req <= cpu_req;
    end
  end

  // low address bits are ignored
  always_comb
  begin
    word_addr               = req.address;
    word_addr.fields.offset = '0;
  end

  assign fetch_match = (mem_req.fetch_address.raw == word_addr.raw);
  assign lookup_addr = req.address;

  // line update, fill on read miss or write-allocate
  always_comb
  begin
    line_write.enable = 1'b0;
    line_write.index  = req.address.fields.index;
    line_write.tag    = req.address.fields.tag;
    line_write.data   = fetch_read_data;
    case (state)
      cache_bus_pkg::READ:
      begin
        line_write.enable = !lookup.hit && fetch_match;
      end
      cache_bus_pkg::WRITE:
      begin
        line_write.enable = 1'b1;
        line_write.data   = req.data;
      end
      default:
      begin
        line_write.enable = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state   <= cache_bus_pkg::IDLE;
      cpu_rsp <= '0;
      mem_req <= '0;
    end
    else
    begin
      // both strobes are single-cycle pulses
      cpu_rsp.data_ready         <= 1'b0;
      mem_req.fetch_write_enable <= 1'b0;
      case (state)
        cache_bus_pkg::IDLE:
        begin
          // write wins over read
          if (cpu_req.write_enable)
          begin
            state <= cache_bus_pkg::WRITE;
          end
          else if (cpu_req.read_enable)
          begin
            state <= cache_bus_pkg::READ;
          end
        end
        cache_bus_pkg::READ:
        begin
          if (lookup.hit)
          begin
            cpu_rsp.data_ready <= 1'b1;
            cpu_rsp.data       <= lookup.data;
            state              <= cache_bus_pkg::IDLE;
          end
          else if (fetch_match)
          begin
            cpu_rsp.data_ready <= 1'b1;
            cpu_rsp.data       <= fetch_read_data;
            state              <= cache_bus_pkg::IDLE;
          end
          else
          begin
            // memory answers next cycle at the new address
            mem_req.fetch_address <= word_addr;
          end
        end
        cache_bus_pkg::WRITE:
        begin
          mem_req.fetch_address      <= word_addr;
          mem_req.fetch_write_data   <= req.data;
          mem_req.fetch_write_enable <= 1'b1;
          cpu_rsp.data_ready         <= 1'b1;
          cpu_rsp.data               <= req.data;
          state                      <= cache_bus_pkg::IDLE;
        end
        default:
        begin
          state <= cache_bus_pkg::IDLE;
        end
      endcase
    end
  end

  ready_is_pulse: assert property (
    @(posedge clk) disable iff (reset)
    cpu_rsp.data_ready |=> !cpu_rsp.data_ready
  );

  // pulse only in the cycle after WRITE was entered from idle
  write_after_write_state: assert property (
    @(posedge clk) disable iff (reset)
    mem_req.fetch_write_enable |->
      ($past(state) == cache_bus_pkg::WRITE) && ($past(state, 2) == cache_bus_pkg::IDLE)
  );

endmodule

/* hw/cache_geom_pkg.sv */
package cache_geom_pkg;

  // address split: tag | index | byte offset
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int INDEX_W    = 3;
  localparam int TAG_W      = 27;
  localparam int OFFSET_W   = 2;
  localparam int LINE_COUNT = 8;

  typedef logic [INDEX_W-1:0] cache_index_t;

  typedef logic [TAG_W-1:0] cache_tag_t;

  typedef logic [DATA_W-1:0] cache_word_t;

  // field view of an address, msb first
  typedef struct packed {
    cache_tag_t            tag;
    cache_index_t          index;
    logic [OFFSET_W-1:0]   offset;
  } cache_addr_fields_s;

  // raw for the memory bus and address compares,
  // fields for the line lookup
  typedef union packed {
    logic [ADDR_W-1:0]  raw;
    cache_addr_fields_s fields;
  } cache_addr_u;

endpackage

/* hw/cache_line.sv */
module cache_line #(
  parameter cache_geom_pkg::cache_index_t LINE_INDEX = '0
) (
  input  logic                        clk,
  input  logic                        reset,
  input  cache_geom_pkg::cache_addr_u lookup_addr,
  input  cache_bus_pkg::line_write_s  line_write,
  output cache_bus_pkg::line_read_s   line_read
);

  logic                        valid;
  cache_geom_pkg::cache_tag_t  tag;
  cache_geom_pkg::cache_word_t data;
  logic                        write_here;
  logic                        index_match;

  assign write_here  = line_write.enable && (line_write.index == LINE_INDEX);
  assign index_match = (lookup_addr.fields.index == LINE_INDEX);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      valid <= 1'b0;
    end
    else if (write_here)
    begin
      valid <= 1'b1;
    end
  end

  // tag and word, rewritten on every fill
  always_ff @(posedge clk)
  begin
    if (write_here)
    begin
      tag  <= line_write.tag;
      data <= line_write.data;
    end
  end

  assign line_read.hit  = valid && index_match && (tag == lookup_addr.fields.tag);
  assign line_read.data = data;

  // no invalidation path exists, lines only ever fill
  valid_never_drops: assert property (
    @(posedge clk) disable iff (reset)
    valid |=> valid
  );

endmodule

/* hw/cache_top.sv */
module cache_top (
  input  logic                        clk,
  input  logic                        reset,
  input  cache_bus_pkg::cpu_req_s     cpu_req,
  output cache_bus_pkg::cpu_rsp_s     cpu_rsp,
  output cache_bus_pkg::mem_req_s     mem_req,
  input  cache_geom_pkg::cache_word_t fetch_read_data
);

  cache_geom_pkg::cache_addr_u lookup_addr;
  cache_bus_pkg::line_write_s  line_write;
  cache_bus_pkg::lookup_s      lookup;
  cache_bus_pkg::line_read_s   line_reads [cache_geom_pkg::LINE_COUNT];

  cache_ctrl cache_ctrl_i (
    .clk             (clk),
    .reset           (reset),
    .cpu_req         (cpu_req),
    .cpu_rsp         (cpu_rsp),
    .mem_req         (mem_req),
    .fetch_read_data (fetch_read_data),
    .lookup_addr     (lookup_addr),
    .line_write      (line_write),
    .lookup          (lookup)
  );

  // one instance per line, each knows its own index
  for (genvar i = 0; i < cache_geom_pkg::LINE_COUNT; i++)
  begin : gen_lines
    cache_line #(
      .LINE_INDEX (cache_geom_pkg::cache_index_t'(i))
    ) cache_line_i (
      .clk         (clk),
      .reset       (reset),
      .lookup_addr (lookup_addr),
      .line_write  (line_write),
      .line_read   (line_reads[i])
    );
  end

  hit_select hit_select_i (
    .lines  (line_reads),
    .lookup (lookup)
  );

endmodule

/* hw/hit_select.sv */
module hit_select (
  input  cache_bus_pkg::line_read_s lines [cache_geom_pkg::LINE_COUNT],
  output cache_bus_pkg::lookup_s    lookup
);

  logic [cache_geom_pkg::LINE_COUNT-1:0] hits;

  always_comb
  begin
    for (int i = 0; i < cache_geom_pkg::LINE_COUNT; i++)
    begin
      hits[i] = lines[i].hit;
    end
  end

  // and-or mux, zero when nothing hits
  always_comb
  begin
    lookup = '0;
    for (int i = 0; i < cache_geom_pkg::LINE_COUNT; i++)
    begin
      lookup.hit  = lookup.hit | lines[i].hit;
      lookup.data = lookup.data | ({cache_geom_pkg::DATA_W{lines[i].hit}} & lines[i].data);
    end
  end

  // index compare inside each line keeps hits exclusive
  always_comb
  begin
    single_hit: assert final ($onehot0(hits))
    else
      $error("more than one cache line hit: %b", hits);
  end

endmodule

/* tb.f */
hw/cache_geom_pkg.sv
hw/cache_bus_pkg.sv
hw/cache_line.sv
hw/hit_select.sv
hw/cache_ctrl.sv
hw/cache_top.sv
verif/clk_gen.sv
verif/cache_tb.sv

/* verif/cache_tb.sv */
module cache_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD_NS = 10;
  localparam int RESET_CYCLES  = 10;
  localparam int OP_COUNT      = 50;
  localparam int CYCLES_PER_OP = 5;
  localparam int MARGIN_CYCLES = 100;
  localparam int TIMEOUT_NS    =
    (OP_COUNT * CYCLES_PER_OP + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS;
  localparam logic [31:0] FILL_KEY = 32'h5A5A_0000;

  logic                        clk;
  logic                        reset;
  cache_bus_pkg::cpu_req_s     cpu_req;
  cache_bus_pkg::cpu_rsp_s     cpu_rsp;
  cache_bus_pkg::mem_req_s     mem_req;
  cache_geom_pkg::cache_word_t fetch_read_data;

  // bus-side memory, and what the tests expect it to hold
  cache_geom_pkg::cache_word_t mem [logic [31:0]];
  cache_geom_pkg::cache_word_t model [logic [31:0]];
  int                          mem_version = 0;
  integer                      seed = 67;

  clk_gen #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (RESET_CYCLES)
  ) clk_gen_i (
    .clk   (clk),
    .reset (reset)
  );

  cache_top cache_top_i (
    .clk             (clk),
    .reset           (reset),
    .cpu_req         (cpu_req),
    .cpu_rsp         (cpu_rsp),
    .mem_req         (mem_req),
    .fetch_read_data (fetch_read_data)
  );

  function automatic logic [31:0] word_of(input logic [31:0] addr);
    return {addr[31:2], 2'b00};
  endfunction

  // unwritten words read back as address xor key
  function automatic cache_geom_pkg::cache_word_t fill_value(input logic [31:0] addr);
    return word_of(addr) ^ FILL_KEY;
  endfunction

  function automatic cache_geom_pkg::cache_word_t mem_read(input logic [31:0] addr);
    if (mem.exists(word_of(addr)))
    begin
      return mem[word_of(addr)];
    end
    return fill_value(addr);
  endfunction

  function automatic cache_geom_pkg::cache_word_t expected_word(input logic [31:0] addr);
    if (model.exists(word_of(addr)))
    begin
      return model[word_of(addr)];
    end
    return fill_value(addr);
  endfunction

  // combinational read port, also follows writes
  always
  begin
    fetch_read_data = mem_read(mem_req.fetch_address.raw);
    @(mem_req.fetch_address or mem_version);
  end

  always @(posedge clk)
  begin
    if (mem_req.fetch_write_enable === 1'b1)
    begin
      mem[word_of(mem_req.fetch_address.raw)] = mem_req.fetch_write_data;
      mem_version++;
    end
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic compare_word(input string name, input cache_geom_pkg::cache_word_t got,
                              input cache_geom_pkg::cache_word_t expected);
    if (got !== expected)
    begin
      report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, expected));
    end
  endtask

  task automatic compare_addr(input string name, input cache_geom_pkg::cache_addr_u got,
                              input cache_geom_pkg::cache_addr_u expected);
    if (got.raw !== expected.raw)
    begin
      report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got.raw,
                               expected.raw));
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic expected);
    if (got !== expected)
    begin
      report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, expected));
    end
  endtask

  // miss with a new fetch address takes two cycles after sampling
  task automatic wait_ready();
    logic seen;
    seen = 1'b0;
    for (int i = 0; i < 3 && !seen; i++)
    begin
      @(posedge clk);
      #1;
      seen = cpu_rsp.data_ready;
    end
    if (!seen)
    begin
      report_failure($sformatf("no data_ready after request to address 0x%h",
                               cpu_req.address.raw));
    end
  endtask

  task automatic read_word(input logic [31:0] addr, output cache_geom_pkg::cache_word_t data);
    @(posedge clk);
    #1;
    cpu_req.address.raw  = addr;
    cpu_req.write_enable = 1'b0;
    cpu_req.read_enable  = 1'b1;
    wait_ready();
    cpu_req.read_enable = 1'b0;
    data = cpu_rsp.data;
  endtask

  task automatic write_word(input logic [31:0] addr, input cache_geom_pkg::cache_word_t data);
    cache_geom_pkg::cache_addr_u word_addr;
    word_addr.raw = word_of(addr);
    @(posedge clk);
    #1;
    cpu_req.address.raw  = addr;
    cpu_req.data         = data;
    cpu_req.write_enable = 1'b1;
    cpu_req.read_enable  = 1'b0;
    wait_ready();
    cpu_req.write_enable = 1'b0;
    compare_word("cpu_rsp.data", cpu_rsp.data, data);
    compare_bit("mem_req.fetch_write_enable", mem_req.fetch_write_enable, 1'b1);
    compare_addr("mem_req.fetch_address", mem_req.fetch_address, word_addr);
    compare_word("mem_req.fetch_write_data", mem_req.fetch_write_data, data);
    model[word_addr.raw] = data;
    // one pulse only
    @(posedge clk);
    #1;
    compare_bit("mem_req.fetch_write_enable", mem_req.fetch_write_enable, 1'b0);
  endtask

  task automatic test_reset();
    compare_bit("cpu_rsp.data_ready", cpu_rsp.data_ready, 1'b0);
    compare_bit("mem_req.fetch_write_enable", mem_req.fetch_write_enable, 1'b0);
    compare_addr("mem_req.fetch_address", mem_req.fetch_address, '0);
    compare_word("cpu_rsp.data", cpu_rsp.data, '0);
  endtask

  task automatic test_read_miss_then_hit();
    cache_geom_pkg::cache_addr_u addr;
    cache_geom_pkg::cache_addr_u other;
    cache_geom_pkg::cache_word_t data;
    addr.raw  = 32'h0001_2344;
    other.raw = 32'h0001_2350;
    read_word(addr.raw, data);
    compare_word("cpu_rsp.data", data, expected_word(addr.raw));
    compare_addr("mem_req.fetch_address", mem_req.fetch_address, addr);
    // move the bus to another line so a refetch would show
    read_word(other.raw, data);
    compare_word("cpu_rsp.data", data, expected_word(other.raw));
    read_word(addr.raw, data);
    compare_word("cpu_rsp.data", data, expected_word(addr.raw));
    compare_addr("mem_req.fetch_address", mem_req.fetch_address, other);
  endtask

  task automatic test_write_through();
    cache_geom_pkg::cache_addr_u addr;
    cache_geom_pkg::cache_word_t data;
    addr.raw = 32'h0003_456C;
    write_word(addr.raw, 32'hCAFE_0123);
    read_word(addr.raw, data);
    compare_word("cpu_rsp.data", data, 32'hCAFE_0123);
    compare_addr("mem_req.fetch_address", mem_req.fetch_address, addr);
  endtask

  // same index, different tag
  task automatic test_conflict_eviction();
    cache_geom_pkg::cache_addr_u addr_a;
    cache_geom_pkg::cache_addr_u addr_b;
    cache_geom_pkg::cache_word_t data;
    addr_a.raw = 32'h0010_0008;
    addr_b.raw = 32'h0020_0008;
    read_word(addr_a.raw, data);
    compare_addr("mem_req.fetch_address", mem_req.fetch_address, addr_a);
    read_word(addr_b.raw, data);
    compare_word("cpu_rsp.data", data, expected_word(addr_b.raw));
    compare_addr("mem_req.fetch_address", mem_req.fetch_address, addr_b);
    read_word(addr_a.raw, data);
    compare_word("cpu_rsp.data", data, expected_word(addr_a.raw));
    compare_addr("mem_req.fetch_address", mem_req.fetch_address, addr_a);
  endtask

  task automatic test_ignored_offset();
    cache_geom_pkg::cache_addr_u base;
    cache_geom_pkg::cache_word_t data;
    base.raw = 32'h0040_0014;
    read_word(base.raw | 32'h3, data);
    compare_word("cpu_rsp.data", data, expected_word(base.raw));
    compare_addr("mem_req.fetch_address", mem_req.fetch_address, base);
    read_word(base.raw | 32'h1, data);
    compare_word("cpu_rsp.data", data, expected_word(base.raw));
  endtask

  task automatic test_random_sequence();
    logic [31:0]                 addrs [16];
    cache_geom_pkg::cache_tag_t  tags [4];
    logic [31:0]                 r;
    cache_geom_pkg::cache_word_t data;
    tags[0] = 27'h0000123;
    tags[1] = 27'h00045A0;
    tags[2] = 27'h1F00001;
    tags[3] = 27'h0A0B0C0;
    // four tags over the odd indices
    for (int t = 0; t < 4; t++)
    begin
      for (int i = 0; i < 4; i++)
      begin
        addrs[t * 4 + i] = {tags[t], cache_geom_pkg::cache_index_t'(2 * i + 1), 2'b00};
      end
    end
    for (int n = 0; n < 40; n++)
    begin
      r = $random(seed);
      if (r[4])
      begin
        write_word(addrs[r[3:0]], $random(seed));
      end
      else
      begin
        read_word(addrs[r[3:0]], data);
        compare_word("cpu_rsp.data", data, expected_word(addrs[r[3:0]]));
      end
    end
  endtask

  initial
  begin
    #(TIMEOUT_NS);
    report_failure("watchdog expired before the tests finished");
  end

  initial
  begin
    cpu_req = '0;
    @(negedge reset);
    test_reset();
    test_read_miss_then_hit();
    test_write_through();
    test_conflict_eviction();
    test_ignored_offset();
    test_random_sequence();
    $display("Testbench passed");
    $finish;
  end

endmodule

/* verif/clk_gen.sv */
module clk_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic reset
);

  timeunit 1ns;
  timeprecision 1ps;

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(PERIOD_NS / 2) clk = ~clk;
    end
  end

  // release lines up with the tb drive offset
  initial
  begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule
